/* rtl/overlay_pkg.sv */
`default_nettype none

// shared stream definitions for the overlay stage
package overlay_pkg;

   // width of the data type token carried next to every stream beat
   localparam int DTYPE_WIDTH = 3;

   // token that tells what a beat on the stream means
   // pixels only appear between a row start and a row end, and rows only
   // appear between a frame start and a frame end
   // headers carry their payload in the metadata word and may show up
   // anywhere outside a row
   typedef enum logic [DTYPE_WIDTH-1:0] {
      // first beat of a frame, clears the position counters
      DTYPE_FRAME_START = 3'd0,
      // opens a row of pixels
      DTYPE_ROW_START   = 3'd1,
      // one pixel of the image in the three colour channels
      DTYPE_PIXEL       = 3'd2,
      // closes a row, moves the tracker to the next row
      DTYPE_ROW_END     = 3'd3,
      // last beat of a frame
      DTYPE_FRAME_END   = 3'd4,
      // side information, metadata is the payload
      DTYPE_HEADER      = 3'd5
   } dtype_t;

   // codes 6 and 7 are unused on the stream
   // the overlay stage passes them through like any other non-pixel token

endpackage : overlay_pkg

`default_nettype wire

/* rtl/overlay_window.sv */
`timescale 1ns/100ps
`default_nettype none

// tracks the raster position of the base stream and decides which pixels
// fall inside the overlay window
// the base beat is registered once here, so stage 1 lines up with the
// overlay pixel that the fetcher registers in the same cycle
module overlay_window
   import overlay_pkg::*;
#(
   parameter int PIXEL_WIDTH = 8,
   parameter int DATA_WIDTH  = 16,
   parameter int DIM_WIDTH   = 11
) (
   input  wire logic                   clk,
   input  wire logic                   resetb,
   input  wire logic                   enable,

   input  wire logic [DIM_WIDTH-1:0]   row_start,
   input  wire logic [DIM_WIDTH-1:0]   col_start,
   input  wire logic [DIM_WIDTH-1:0]   num_overlay_rows,
   input  wire logic [DIM_WIDTH-1:0]   num_overlay_cols,

   input  wire logic                   dvi,
   input  wire dtype_t                 dtypei,
   input  wire logic [PIXEL_WIDTH-1:0] data0i,
   input  wire logic [PIXEL_WIDTH-1:0] data1i,
   input  wire logic [PIXEL_WIDTH-1:0] data2i,
   input  wire logic [DATA_WIDTH-1:0]  meta_datai,

   output logic                        in_window,
   output logic                        overlay_restart,

   output logic                        s1_dv,
   output dtype_t                      s1_dtype,
   output logic [PIXEL_WIDTH-1:0]      s1_data0,
   output logic [PIXEL_WIDTH-1:0]      s1_data1,
   output logic [PIXEL_WIDTH-1:0]      s1_data2,
   output logic [DATA_WIDTH-1:0]       s1_meta,
   output logic                        s1_blend
);

   // position of the current input beat inside the base image
   logic [DIM_WIDTH-1:0] row_pos;
   logic [DIM_WIDTH-1:0] col_pos;

   // window bounds, exclusive at the far edge
   // the window is assumed to stay inside the base image, so no clipping
   logic [DIM_WIDTH-1:0] row_end;
   logic [DIM_WIDTH-1:0] col_end;

   logic row_hit;
   logic col_hit;

   assign row_end = row_start + num_overlay_rows;
   assign col_end = col_start + num_overlay_cols;

   assign row_hit = (row_pos >= row_start) && (row_pos < row_end);
   assign col_hit = (col_pos >= col_start) && (col_pos < col_end);

   // combinational, the fetcher advances its read pointer on this
   assign in_window = enable && dvi && (dtypei == DTYPE_PIXEL) && row_hit && col_hit;

   // raster counters
   // the column counts pixels in the row and the row counts row ends,
   // so headers and row starts leave the position alone
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_pos <= '0;
         col_pos <= '0;
      end else if (!enable) begin
         // hold at the origin while bypassed so a later enable starts clean
         row_pos <= '0;
         col_pos <= '0;
      end else if (dvi) begin
         case (dtypei)
            DTYPE_FRAME_START: begin
               row_pos <= '0;
               col_pos <= '0;
            end
            DTYPE_ROW_END: begin
               row_pos <= row_pos + 1'b1;
               col_pos <= '0;
            end
            DTYPE_PIXEL: begin
               col_pos <= col_pos + 1'b1;
            end
            default: begin
               row_pos <= row_pos;
               col_pos <= col_pos;
            end
         endcase
      end
   end

   // stage 1 of the base stream, taken every cycle since there is no stall
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         s1_dv           <= 1'b0;
         s1_dtype        <= dtype_t'('0);
         s1_data0        <= '0;
         s1_data1        <= '0;
         s1_data2        <= '0;
         s1_meta         <= '0;
         s1_blend        <= 1'b0;
         overlay_restart <= 1'b0;
      end else begin
         s1_dv           <= dvi;
         s1_dtype        <= dtypei;
         s1_data0        <= data0i;
         s1_data1        <= data1i;
         s1_data2        <= data2i;
         s1_meta         <= meta_datai;
         s1_blend        <= in_window;
         // a sync pulse for whoever supplies the overlay image
         overlay_restart <= enable && dvi && (dtypei == DTYPE_FRAME_START);
      end
   end

   // a blend flag in stage 1 must belong to a valid pixel beat that was
   // seen while the stage was enabled
   a_blend_only_on_pixel : assert property (
      @(posedge clk) disable iff (!resetb)
      s1_blend |-> s1_dv && (s1_dtype == DTYPE_PIXEL) && $past(enable)
   );

endmodule : overlay_window

`default_nettype wire

/* rtl/overlay_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

// holds the overlay image and hands out one overlay pixel per windowed
// base pixel, in raster order starting at address zero
// the stored alpha is scaled by the global alpha on the way out
module overlay_fetch
   import overlay_pkg::*;
#(
   parameter int PIXEL_WIDTH    = 8,
   parameter int ALPHA_WIDTH    = 8,
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  wire logic                      clk,
   input  wire logic                      resetb,
   input  wire logic                      enable,
   input  wire logic                      in_window,
   input  wire dtype_t                    dtypei,
   input  wire logic                      dvi,

   input  wire logic [ALPHA_WIDTH-1:0]    global_alpha,

   input  wire logic                      ovl_we,
   input  wire logic [OVL_ADDR_WIDTH-1:0] ovl_waddr,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata0,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata1,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata2,
   input  wire logic [ALPHA_WIDTH-1:0]    ovl_walpha,

   output logic [PIXEL_WIDTH-1:0]         s1_ovl0,
   output logic [PIXEL_WIDTH-1:0]         s1_ovl1,
   output logic [PIXEL_WIDTH-1:0]         s1_ovl2,
   output logic [ALPHA_WIDTH-1:0]         s1_alpha
);

   localparam int OVL_DEPTH = 2 ** OVL_ADDR_WIDTH;

   // overlay store, one entry per overlay pixel in raster order
   logic [PIXEL_WIDTH-1:0] mem0 [OVL_DEPTH];
   logic [PIXEL_WIDTH-1:0] mem1 [OVL_DEPTH];
   logic [PIXEL_WIDTH-1:0] mem2 [OVL_DEPTH];
   logic [ALPHA_WIDTH-1:0] mema [OVL_DEPTH];

   logic [OVL_ADDR_WIDTH-1:0] rd_ptr;

   // stored alpha of the addressed entry and its scaled forms
   logic [ALPHA_WIDTH-1:0]   rd_alpha;
   logic [2*ALPHA_WIDTH-1:0] alpha_prod;
   logic [ALPHA_WIDTH-1:0]   eff_alpha;

   // host write port, only used while the stage is bypassed
   always_ff @(posedge clk) begin
      if (ovl_we) begin
         mem0[ovl_waddr] <= ovl_wdata0;
         mem1[ovl_waddr] <= ovl_wdata1;
         mem2[ovl_waddr] <= ovl_wdata2;
         mema[ovl_waddr] <= ovl_walpha;
      end
   end

   // read pointer walks the store once per frame
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_ptr <= '0;
      end else if (!enable || (dvi && dtypei == DTYPE_FRAME_START)) begin
         rd_ptr <= '0;
      end else if (in_window) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // a full global alpha leaves the stored alpha untouched, since the
   // upper half of the product would lose one code at the top
   assign rd_alpha   = mema[rd_ptr];
   assign alpha_prod = rd_alpha * global_alpha;
   assign eff_alpha  = (&global_alpha) ? rd_alpha : alpha_prod[2*ALPHA_WIDTH-1:ALPHA_WIDTH];

   // stage 1 of the overlay, loaded in the same cycle the base beat is
   // registered in the window tracker
   // outside the window the blender ignores these, so they just hold
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         s1_ovl0  <= '0;
         s1_ovl1  <= '0;
         s1_ovl2  <= '0;
         s1_alpha <= '0;
      end else if (in_window) begin
         s1_ovl0  <= mem0[rd_ptr];
         s1_ovl1  <= mem1[rd_ptr];
         s1_ovl2  <= mem2[rd_ptr];
         s1_alpha <= eff_alpha;
      end
   end

   // the host may only load the store while the stage is bypassed
   a_no_write_when_enabled : assert property (
      @(posedge clk) disable iff (!resetb)
      ovl_we |-> !enable
   );

endmodule : overlay_fetch

`default_nettype wire

/* rtl/overlay_blend.sv */
`timescale 1ns/100ps
`default_nettype none

// mixes the delayed base pixel with the fetched overlay pixel and drives
// the output stream
// each channel is mixed the same way, so RGB and YUV need no distinction
module overlay_blend
   import overlay_pkg::*;
#(
   parameter int PIXEL_WIDTH = 8,
   parameter int ALPHA_WIDTH = 8,
   parameter int DATA_WIDTH  = 16
) (
   input  wire logic                   clk,
   input  wire logic                   resetb,

   input  wire logic                   s1_dv,
   input  wire dtype_t                 s1_dtype,
   input  wire logic [PIXEL_WIDTH-1:0] s1_data0,
   input  wire logic [PIXEL_WIDTH-1:0] s1_data1,
   input  wire logic [PIXEL_WIDTH-1:0] s1_data2,
   input  wire logic [DATA_WIDTH-1:0]  s1_meta,
   input  wire logic                   s1_blend,

   input  wire logic [PIXEL_WIDTH-1:0] s1_ovl0,
   input  wire logic [PIXEL_WIDTH-1:0] s1_ovl1,
   input  wire logic [PIXEL_WIDTH-1:0] s1_ovl2,
   input  wire logic [ALPHA_WIDTH-1:0] s1_alpha,

   output logic                        dvo,
   output dtype_t                      dtypeo,
   output logic [PIXEL_WIDTH-1:0]      data0o,
   output logic [PIXEL_WIDTH-1:0]      data1o,
   output logic [PIXEL_WIDTH-1:0]      data2o,
   output logic [DATA_WIDTH-1:0]       meta_datao
);

   // one channel of the mix
   // treating alpha as a fraction of all ones, the result is
   // overlay * alpha + base * (1 - alpha)
   // the two ends are taken exactly, since the truncated product would
   // otherwise fall one code short of the overlay or the base
   function automatic logic [PIXEL_WIDTH-1:0] blend_px(
      input logic [PIXEL_WIDTH-1:0] base,
      input logic [PIXEL_WIDTH-1:0] ovl,
      input logic [ALPHA_WIDTH-1:0] alpha
   );
      logic [ALPHA_WIDTH-1:0]             alpha_comp;
      logic [PIXEL_WIDTH+ALPHA_WIDTH-1:0] sum;
      alpha_comp = {ALPHA_WIDTH{1'b1}} - alpha;
      // weights add up to all ones, so the sum cannot overflow
      sum = (alpha * ovl) + (alpha_comp * base);
      if (alpha == '0) begin
         return base;
      end else if (alpha_comp == '0) begin
         return ovl;
      end
      return sum[PIXEL_WIDTH+ALPHA_WIDTH-1:ALPHA_WIDTH];
   endfunction

   logic [PIXEL_WIDTH-1:0] mix0;
   logic [PIXEL_WIDTH-1:0] mix1;
   logic [PIXEL_WIDTH-1:0] mix2;

   // outside the window the base goes through untouched
   always_comb begin
      if (s1_blend) begin
         mix0 = blend_px(s1_data0, s1_ovl0, s1_alpha);
         mix1 = blend_px(s1_data1, s1_ovl1, s1_alpha);
         mix2 = blend_px(s1_data2, s1_ovl2, s1_alpha);
      end else begin
         mix0 = s1_data0;
         mix1 = s1_data1;
         mix2 = s1_data2;
      end
   end

   // output register, the token and metadata ride along unchanged
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo        <= 1'b0;
         dtypeo     <= dtype_t'('0);
         data0o     <= '0;
         data1o     <= '0;
         data2o     <= '0;
         meta_datao <= '0;
      end else begin
         dvo        <= s1_dv;
         dtypeo     <= s1_dtype;
         data0o     <= mix0;
         data1o     <= mix1;
         data2o     <= mix2;
         meta_datao <= s1_meta;
      end
   end

endmodule : overlay_blend

`default_nettype wire

/* rtl/overlay_top.sv */
`timescale 1ns/100ps
`default_nettype none

// overlay stage for a tokenized pixel stream
// the window tracker and the fetcher run side by side on the input beat,
// and the blender mixes their stage 1 results into the output stream
// a beat at the input shows up at the output two cycles later
module overlay_top
   import overlay_pkg::*;
#(
   parameter int PIXEL_WIDTH    = 8,
   parameter int ALPHA_WIDTH    = 8,
   parameter int DATA_WIDTH     = 16,
   parameter int DIM_WIDTH      = 11,
   parameter int OVL_ADDR_WIDTH = 10
) (
   input  wire logic                      clk,
   input  wire logic                      resetb,

   // settings, expected to stay put during a frame
   input  wire logic                      enable,
   input  wire logic [DIM_WIDTH-1:0]      row_start,
   input  wire logic [DIM_WIDTH-1:0]      col_start,
   input  wire logic [DIM_WIDTH-1:0]      num_overlay_rows,
   input  wire logic [DIM_WIDTH-1:0]      num_overlay_cols,
   input  wire logic [ALPHA_WIDTH-1:0]    global_alpha,

   // base stream
   input  wire logic                      dvi,
   input  wire dtype_t                    dtypei,
   input  wire logic [PIXEL_WIDTH-1:0]    data0i,
   input  wire logic [PIXEL_WIDTH-1:0]    data1i,
   input  wire logic [PIXEL_WIDTH-1:0]    data2i,
   input  wire logic [DATA_WIDTH-1:0]     meta_datai,

   // host loads the overlay store through this port while disabled
   input  wire logic                      ovl_we,
   input  wire logic [OVL_ADDR_WIDTH-1:0] ovl_waddr,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata0,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata1,
   input  wire logic [PIXEL_WIDTH-1:0]    ovl_wdata2,
   input  wire logic [ALPHA_WIDTH-1:0]    ovl_walpha,

   // blended stream
   output logic                           dvo,
   output dtype_t                         dtypeo,
   output logic [PIXEL_WIDTH-1:0]         data0o,
   output logic [PIXEL_WIDTH-1:0]         data1o,
   output logic [PIXEL_WIDTH-1:0]         data2o,
   output logic [DATA_WIDTH-1:0]          meta_datao,

   output logic                           overlay_restart
);

   logic                   in_window;

   // stage 1 base beat from the window tracker
   logic                   s1_dv;
   dtype_t                 s1_dtype;
   logic [PIXEL_WIDTH-1:0] s1_data0;
   logic [PIXEL_WIDTH-1:0] s1_data1;
   logic [PIXEL_WIDTH-1:0] s1_data2;
   logic [DATA_WIDTH-1:0]  s1_meta;
   logic                   s1_blend;

   // stage 1 overlay pixel and scaled alpha from the fetcher
   logic [PIXEL_WIDTH-1:0] s1_ovl0;
   logic [PIXEL_WIDTH-1:0] s1_ovl1;
   logic [PIXEL_WIDTH-1:0] s1_ovl2;
   logic [ALPHA_WIDTH-1:0] s1_alpha;

   overlay_window #(
      .PIXEL_WIDTH (PIXEL_WIDTH),
      .DATA_WIDTH  (DATA_WIDTH),
      .DIM_WIDTH   (DIM_WIDTH)
   ) u_window (
      .clk              (clk),
      .resetb           (resetb),
      .enable           (enable),
      .row_start        (row_start),
      .col_start        (col_start),
      .num_overlay_rows (num_overlay_rows),
      .num_overlay_cols (num_overlay_cols),
      .dvi              (dvi),
      .dtypei           (dtypei),
      .data0i           (data0i),
      .data1i           (data1i),
      .data2i           (data2i),
      .meta_datai       (meta_datai),
      .in_window        (in_window),
      .overlay_restart  (overlay_restart),
      .s1_dv            (s1_dv),
      .s1_dtype         (s1_dtype),
      .s1_data0         (s1_data0),
      .s1_data1         (s1_data1),
      .s1_data2         (s1_data2),
      .s1_meta          (s1_meta),
      .s1_blend         (s1_blend)
   );

   overlay_fetch #(
      .PIXEL_WIDTH    (PIXEL_WIDTH),
      .ALPHA_WIDTH    (ALPHA_WIDTH),
      .OVL_ADDR_WIDTH (OVL_ADDR_WIDTH)
   ) u_fetch (
      .clk          (clk),
      .resetb       (resetb),
      .enable       (enable),
      .in_window    (in_window),
      .dtypei       (dtypei),
      .dvi          (dvi),
      .global_alpha (global_alpha),
      .ovl_we       (ovl_we),
      .ovl_waddr    (ovl_waddr),
      .ovl_wdata0   (ovl_wdata0),
      .ovl_wdata1   (ovl_wdata1),
      .ovl_wdata2   (ovl_wdata2),
      .ovl_walpha   (ovl_walpha),
      .s1_ovl0      (s1_ovl0),
      .s1_ovl1      (s1_ovl1),
      .s1_ovl2      (s1_ovl2),
      .s1_alpha     (s1_alpha)
   );

   overlay_blend #(
      .PIXEL_WIDTH (PIXEL_WIDTH),
      .ALPHA_WIDTH (ALPHA_WIDTH),
      .DATA_WIDTH  (DATA_WIDTH)
   ) u_blend (
      .clk        (clk),
      .resetb     (resetb),
      .s1_dv      (s1_dv),
      .s1_dtype   (s1_dtype),
      .s1_data0   (s1_data0),
      .s1_data1   (s1_data1),
      .s1_data2   (s1_data2),
      .s1_meta    (s1_meta),
      .s1_blend   (s1_blend),
      .s1_ovl0    (s1_ovl0),
      .s1_ovl1    (s1_ovl1),
      .s1_ovl2    (s1_ovl2),
      .s1_alpha   (s1_alpha),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .data0o     (data0o),
      .data1o     (data1o),
      .data2o     (data2o),
      .meta_datao (meta_datao)
   );

endmodule : overlay_top

`default_nettype wire

/* tests/overlay_tb_tasks.svh */
// stimulus and model tasks, included into overlay_tb and using its signals

// effective alpha, the stored alpha scaled by the global alpha
function automatic int scale_alpha(input int stored, input int ga);
   if (ga == ALPHA_MAX) return stored;
   return (stored * ga) / (1 << ALPHA_WIDTH);
endfunction

// one channel of the mix, with both alpha extremes taken exactly
function automatic int mix_channel(input int base, input int ovl, input int alpha);
   if (alpha == 0) return base;
   if (alpha == ALPHA_MAX) return ovl;
   return (alpha * ovl + (ALPHA_MAX - alpha) * base) / (1 << ALPHA_WIDTH);
endfunction

// drives the settings and records them for the model
task automatic set_config(input logic en, input int rs, input int cs,
                          input int nr, input int nc, input int ga);
   @(posedge clk);
   enable           <= en;
   row_start        <= DIM_WIDTH'(rs);
   col_start        <= DIM_WIDTH'(cs);
   num_overlay_rows <= DIM_WIDTH'(nr);
   num_overlay_cols <= DIM_WIDTH'(nc);
   global_alpha     <= ALPHA_WIDTH'(ga);
   m_enable         = en;
   m_row_start      = rs;
   m_col_start      = cs;
   m_rows           = nr;
   m_cols           = nc;
   m_global_alpha   = ga;
   // the read pointer sits at zero while the stage is disabled
   if (!en) m_ptr = 0;
endtask

// host load of the first entries, alpha forced to an extreme if asked
task automatic load_overlay(input int count, input int alpha_mode);
   logic [31:0] word;
   for (int i = 0; i < count; i++) begin
      word = $random(seed);
      if (alpha_mode == ALPHA_ZERO) word[31:24] = 8'h00;
      if (alpha_mode == ALPHA_FULL) word[31:24] = 8'hff;
      @(posedge clk);
      ovl_we      <= 1'b1;
      ovl_waddr   <= OVL_ADDR_WIDTH'(i);
      ovl_walpha  <= word[31:24];
      ovl_wdata0  <= word[23:16];
      ovl_wdata1  <= word[15:8];
      ovl_wdata2  <= word[7:0];
      ovl_copy[i] = word;
   end
   @(posedge clk);
   ovl_we <= 1'b0;
endtask

// works out the output for one driven beat and queues it with its due cycle
task automatic predict_beat(input dtype_t dt, input logic [7:0] b0, input logic [7:0] b1,
                            input logic [7:0] b2, input logic [15:0] meta);
   int          o0;
   int          o1;
   int          o2;
   int          alpha;
   logic [31:0] word;
   o0 = int'(b0);
   o1 = int'(b1);
   o2 = int'(b2);
   if (m_enable && dt == DTYPE_PIXEL && m_row >= m_row_start && m_row < m_row_start + m_rows
       && m_col >= m_col_start && m_col < m_col_start + m_cols) begin
      word  = ovl_copy[m_ptr];
      alpha = scale_alpha(int'(word[31:24]), m_global_alpha);
      o0    = mix_channel(int'(b0), int'(word[23:16]), alpha);
      o1    = mix_channel(int'(b1), int'(word[15:8]), alpha);
      o2    = mix_channel(int'(b2), int'(word[7:0]), alpha);
      m_ptr++;
   end
   if (m_enable && dt == DTYPE_FRAME_START) exp_restarts++;
   if (!m_enable || dt == DTYPE_FRAME_START) begin
      m_row = 0;
      m_col = 0;
      m_ptr = 0;
   end else if (dt == DTYPE_ROW_END) begin
      m_row++;
      m_col = 0;
   end else if (dt == DTYPE_PIXEL) begin
      m_col++;
   end
   exp_q.push_back({dt, PIXEL_WIDTH'(o0), PIXEL_WIDTH'(o1), PIXEL_WIDTH'(o2), meta});
   // cyc still holds the count before this edge, the beat leaves two edges on
   exp_cyc_q.push_back(cyc + 3);
endtask

task automatic send_beat(input dtype_t dt);
   logic [31:0] px;
   logic [31:0] meta;
   px   = $random(seed);
   meta = $random(seed);
   @(posedge clk);
   dvi        <= 1'b1;
   dtypei     <= dt;
   data0i     <= px[7:0];
   data1i     <= px[15:8];
   data2i     <= px[23:16];
   meta_datai <= meta[15:0];
   predict_beat(dt, px[7:0], px[15:8], px[23:16], meta[15:0]);
endtask

task automatic send_idle();
   @(posedge clk);
   dvi <= 1'b0;
endtask

// a full base frame with a header, random data and metadata on every beat
task automatic send_frame();
   send_beat(DTYPE_FRAME_START);
   send_beat(DTYPE_HEADER);
   for (int r = 0; r < FRAME_ROWS; r++) begin
      send_beat(DTYPE_ROW_START);
      for (int c = 0; c < FRAME_COLS; c++) send_beat(DTYPE_PIXEL);
      send_beat(DTYPE_ROW_END);
   end
   send_beat(DTYPE_FRAME_END);
endtask

task automatic start_test();
   err_mark      = errors;
   exp_restarts  = 0;
   seen_restarts = 0;
endtask

// waits until every queued beat came out, then reports the test
task automatic end_test(input string name);
   while (exp_q.size() != 0) @(posedge clk);
   assert (seen_restarts == exp_restarts) else begin
      $display("ERROR @%0t: %s saw %0d restart pulses, expected %0d",
               $time, name, seen_restarts, exp_restarts);
      errors++;
   end
   tests_run++;
   if (errors == err_mark) begin
      $display("test %s finished without errors", name);
   end else begin
      tests_failed++;
      $display("test %s finished with %0d errors", name, errors - err_mark);
   end
endtask

task automatic run_bypass();
   start_test();
   set_config(1'b0, 2, 3, 3, 4, ALPHA_MAX);
   send_frame();
   send_idle();
   end_test("bypass");
endtask

task automatic window_placement();
   start_test();
   load_overlay(OVL_PIXELS, ALPHA_RANDOM);
   set_config(1'b1, 2, 3, 3, 4, ALPHA_MAX);
   send_frame();
   send_idle();
   end_test("window placement");
endtask

task automatic alpha_extremes();
   start_test();
   set_config(1'b0, 2, 3, 3, 4, ALPHA_MAX);
   load_overlay(OVL_PIXELS, ALPHA_ZERO);
   set_config(1'b1, 2, 3, 3, 4, ALPHA_MAX);
   send_frame();
   send_idle();
   set_config(1'b0, 2, 3, 3, 4, ALPHA_MAX);
   load_overlay(OVL_PIXELS, ALPHA_FULL);
   set_config(1'b1, 2, 3, 3, 4, ALPHA_MAX);
   send_frame();
   send_idle();
   end_test("alpha extremes");
endtask

task automatic global_alpha_scaling();
   start_test();
   set_config(1'b0, 1, 2, 3, 4, 8'h80);
   load_overlay(OVL_PIXELS, ALPHA_RANDOM);
   set_config(1'b1, 1, 2, 3, 4, 8'h80);
   send_frame();
   // the stream goes quiet while the global alpha changes between frames
   send_idle();
   set_config(1'b1, 1, 2, 3, 4, 8'h3c);
   send_frame();
   send_idle();
   end_test("global alpha scaling");
endtask

// two frames back to back must both start the overlay at address zero
task automatic frame_restart();
   start_test();
   set_config(1'b0, 4, 1, 3, 4, 8'hc0);
   load_overlay(OVL_PIXELS, ALPHA_RANDOM);
   set_config(1'b1, 4, 1, 3, 4, 8'hc0);
   send_frame();
   send_frame();
   send_idle();
   end_test("frame restart");
endtask

/* tests/overlay_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// testbench for the overlay stage
// a model predicts each output beat from the driven stream, and a checker
// on the falling edge compares the dvo beats in order and in time
module overlay_tb
   import overlay_pkg::*;
();

   localparam int PIXEL_WIDTH    = 8;
   localparam int ALPHA_WIDTH    = 8;
   localparam int DATA_WIDTH     = 16;
   localparam int DIM_WIDTH      = 11;
   localparam int OVL_ADDR_WIDTH = 10;
   localparam int CLK_PERIOD     = 40;
   localparam int ALPHA_MAX      = (1 << ALPHA_WIDTH) - 1;
   // one output beat packed as token, three channels and metadata
   localparam int BEAT_BITS      = DTYPE_WIDTH + 3 * PIXEL_WIDTH + DATA_WIDTH;

   // every test uses an 8x8 base frame and a 3x4 overlay
   localparam int FRAME_ROWS     = 8;
   localparam int FRAME_COLS     = 8;
   localparam int OVL_PIXELS     = 12;
   // frame start, header and frame end plus each row with its two tokens
   localparam int FRAME_BEATS    = 3 + FRAME_ROWS * (FRAME_COLS + 2);
   localparam int NUM_FRAMES     = 8;
   localparam int NUM_LOADS      = 5;
   localparam int TIMEOUT_CYCLES = 4 + NUM_FRAMES * FRAME_BEATS
                                   + NUM_LOADS * (OVL_PIXELS + 1) + 200;

   localparam int ALPHA_RANDOM   = 0;
   localparam int ALPHA_ZERO     = 1;
   localparam int ALPHA_FULL     = 2;

   logic                      clk;
   logic                      resetb;
   logic                      enable;
   logic [DIM_WIDTH-1:0]      row_start;
   logic [DIM_WIDTH-1:0]      col_start;
   logic [DIM_WIDTH-1:0]      num_overlay_rows;
   logic [DIM_WIDTH-1:0]      num_overlay_cols;
   logic [ALPHA_WIDTH-1:0]    global_alpha;
   logic                      dvi;
   dtype_t                    dtypei;
   logic [PIXEL_WIDTH-1:0]    data0i;
   logic [PIXEL_WIDTH-1:0]    data1i;
   logic [PIXEL_WIDTH-1:0]    data2i;
   logic [DATA_WIDTH-1:0]     meta_datai;
   logic                      ovl_we;
   logic [OVL_ADDR_WIDTH-1:0] ovl_waddr;
   logic [PIXEL_WIDTH-1:0]    ovl_wdata0;
   logic [PIXEL_WIDTH-1:0]    ovl_wdata1;
   logic [PIXEL_WIDTH-1:0]    ovl_wdata2;
   logic [ALPHA_WIDTH-1:0]    ovl_walpha;
   logic                      dvo;
   dtype_t                    dtypeo;
   logic [PIXEL_WIDTH-1:0]    data0o;
   logic [PIXEL_WIDTH-1:0]    data1o;
   logic [PIXEL_WIDTH-1:0]    data2o;
   logic [DATA_WIDTH-1:0]     meta_datao;
   logic                      overlay_restart;

   // model state, a copy of the settings and of the overlay store
   // each store word holds alpha, channel 0, channel 1 and channel 2
   logic [31:0]          ovl_copy [1 << OVL_ADDR_WIDTH];
   logic                 m_enable;
   int                   m_row_start;
   int                   m_col_start;
   int                   m_rows;
   int                   m_cols;
   int                   m_global_alpha;
   int                   m_row;
   int                   m_col;
   int                   m_ptr;
   logic [BEAT_BITS-1:0] exp_q [$];
   int                   exp_cyc_q [$];

   integer seed          = 1141;
   int     cyc           = 0;
   int     errors        = 0;
   int     err_mark      = 0;
   int     beats_checked = 0;
   int     tests_run     = 0;
   int     tests_failed  = 0;
   int     exp_restarts  = 0;
   int     seen_restarts = 0;

   overlay_top #(
      .PIXEL_WIDTH    (PIXEL_WIDTH),
      .ALPHA_WIDTH    (ALPHA_WIDTH),
      .DATA_WIDTH     (DATA_WIDTH),
      .DIM_WIDTH      (DIM_WIDTH),
      .OVL_ADDR_WIDTH (OVL_ADDR_WIDTH)
   ) dut (
      .clk (clk), .resetb (resetb), .enable (enable),
      .row_start (row_start), .col_start (col_start),
      .num_overlay_rows (num_overlay_rows), .num_overlay_cols (num_overlay_cols),
      .global_alpha (global_alpha),
      .dvi (dvi), .dtypei (dtypei), .data0i (data0i), .data1i (data1i),
      .data2i (data2i), .meta_datai (meta_datai),
      .ovl_we (ovl_we), .ovl_waddr (ovl_waddr), .ovl_wdata0 (ovl_wdata0),
      .ovl_wdata1 (ovl_wdata1), .ovl_wdata2 (ovl_wdata2), .ovl_walpha (ovl_walpha),
      .dvo (dvo), .dtypeo (dtypeo), .data0o (data0o), .data1o (data1o),
      .data2o (data2o), .meta_datao (meta_datao),
      .overlay_restart (overlay_restart)
   );

   `include "overlay_tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // the whole run fits well inside this many cycles
   initial begin
      wait (cyc >= TIMEOUT_CYCLES);
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
   end

   // outputs settle after the rising edge, so they are read on the falling one
   always @(negedge clk) begin
      logic [BEAT_BITS-1:0] got;
      logic [BEAT_BITS-1:0] want;
      int                   want_cyc;
      if (overlay_restart) begin
         seen_restarts = seen_restarts + 1;
      end
      if (dvo) begin
         got = {dtypeo, data0o, data1o, data2o, meta_datao};
         assert (exp_q.size() != 0) else begin
            $display("the DUT sent an output beat at %0t that was never driven", $time);
            errors++;
         end
         if (exp_q.size() != 0) begin
            want     = exp_q.pop_front();
            want_cyc = exp_cyc_q.pop_front();
            beats_checked++;
            assert (got == want) else begin
               $display("ERROR @%0t: output beat %h, expected %h", $time, got, want);
               errors++;
            end
            assert (cyc == want_cyc) else begin
               $display("ERROR @%0t: beat left at cycle %0d, expected cycle %0d",
                        $time, cyc, want_cyc);
               errors++;
            end
         end
      end
   end

   initial begin
      resetb           = 1'b0;
      enable           = 1'b0;
      row_start        = '0;
      col_start        = '0;
      num_overlay_rows = '0;
      num_overlay_cols = '0;
      global_alpha     = '0;
      dvi              = 1'b0;
      dtypei           = DTYPE_FRAME_START;
      data0i           = '0;
      data1i           = '0;
      data2i           = '0;
      meta_datai       = '0;
      ovl_we           = 1'b0;
      ovl_waddr        = '0;
      ovl_wdata0       = '0;
      ovl_wdata1       = '0;
      ovl_wdata2       = '0;
      ovl_walpha       = '0;
      m_enable         = 1'b0;
      repeat (4) @(posedge clk);
      assert (!dvo && !overlay_restart && data0o == '0 && data1o == '0 && data2o == '0
              && meta_datao == '0) else begin
         $display("ERROR @%0t: outputs are not cleared while reset is held", $time);
         errors++;
      end
      resetb <= 1'b1;

      run_bypass();
      window_placement();
      alpha_extremes();
      global_alpha_scaling();
      frame_restart();

      $display("%0d tests run, %0d failed, %0d beats checked, %0d errors",
               tests_run, tests_failed, beats_checked, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule : overlay_tb

`default_nettype wire

/* overlay_top.f */
+incdir+tests
rtl/overlay_pkg.sv
rtl/overlay_window.sv
rtl/overlay_fetch.sv
rtl/overlay_blend.sv
rtl/overlay_top.sv
tests/overlay_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module overlay_tb \
   -f overlay_top.f -o overlay_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/overlay_sim > sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
